//--- gs_pkg.sv
//////////////////////////////////////////////////
// shared widths, host address map and job state
// for the gather-scatter engine; every RTL file
// pulls these in with a wildcard import
//////////////////////////////////////////////////

package gs_pkg;

  // datapath and host address widths
  localparam int data_width_lp      = 32;
  localparam int addr_width_lp      = 12;

  // local DMEM geometry
  localparam int dmem_els_lp        = 1024;
  localparam int dmem_addr_width_lp = 10;

  // length runs 0..dmem_els_lp, hence one extra bit
  localparam int len_width_lp       = 11;

  // gather ID pool
  localparam int id_els_lp          = 8;
  localparam int id_width_lp        = 3;

  // wakeup address taken from RUN data bits 17:0
  localparam int wakeup_width_lp    = 18;

  // host word address map
  localparam logic [addr_width_lp-1:0] run_addr_lp    = 12'h000;
  localparam logic [addr_width_lp-1:0] len_addr_lp    = 12'h001;
  localparam logic [addr_width_lp-1:0] stride_addr_lp = 12'h002;
  localparam logic [addr_width_lp-1:0] base_addr_lp   = 12'h003;

  // DMEM window is 0x400..0x7ff
  localparam logic [addr_width_lp-1:0] dmem_base_lp   = 12'h400;

  // load reply for anything outside DMEM
  localparam logic [data_width_lp-1:0] invalid_data_lp = 32'hdeadbeef;

  typedef enum logic [1:0] {
    e_idle,
    e_gather,
    e_scatter,
    e_wakeup
  } gs_state_e;

endpackage

//--- gs_host_port.sv
//////////////////////////////////////////////////
// host side of the engine: decodes requests,
// keeps the job configuration and returns one
// reply exactly one cycle after each request
//////////////////////////////////////////////////

`timescale 1ns/1ps

module gs_host_port
  import gs_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          req_v_i,
  input  logic                          req_we_i,
  input  logic [addr_width_lp-1:0]      req_addr_i,
  input  logic [data_width_lp-1:0]      req_data_i,
  input  logic                          busy_i,
  input  logic [data_width_lp-1:0]      dmem_rdata_i,
  output logic                          req_yumi_o,
  output logic                          resp_v_o,
  output logic [data_width_lp-1:0]      resp_data_o,
  output logic                          run_o,
  output logic                          scatter_o,
  output logic [len_width_lp-1:0]       len_o,
  output logic [data_width_lp-1:0]      stride_o,
  output logic [data_width_lp-1:0]      base_o,
  output logic [wakeup_width_lp-1:0]    wakeup_addr_o,
  output logic                          host_dmem_v_o,
  output logic                          host_dmem_we_o,
  output logic [dmem_addr_width_lp-1:0] host_dmem_addr_o,
  output logic [data_width_lp-1:0]      host_dmem_wdata_o
);

  logic accept;
  logic is_dmem;
  logic resp_v_r;
  logic send_dmem_r;
  logic send_invalid_r;

  // host is only served between jobs
  assign req_yumi_o = ~busy_i;
  assign accept     = req_v_i & req_yumi_o;

  assign is_dmem = (req_addr_i[addr_width_lp-1:dmem_addr_width_lp]
                    == dmem_base_lp[addr_width_lp-1:dmem_addr_width_lp]);

  assign run_o     = accept & req_we_i & (req_addr_i == run_addr_lp);
  assign scatter_o = req_data_i[data_width_lp-1];

  assign host_dmem_v_o     = accept & is_dmem;
  assign host_dmem_we_o    = req_we_i;
  assign host_dmem_addr_o  = req_addr_i[dmem_addr_width_lp-1:0];
  assign host_dmem_wdata_o = req_data_i;

  // configuration registers, write only
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      len_o         <= '0;
      stride_o      <= '0;
      base_o        <= '0;
      wakeup_addr_o <= '0;
    end else if (accept & req_we_i) begin
      if (req_addr_i == len_addr_lp) begin
        len_o <= req_data_i[len_width_lp-1:0];
      end
      if (req_addr_i == stride_addr_lp) begin
        stride_o <= req_data_i;
      end
      if (req_addr_i == base_addr_lp) begin
        base_o <= req_data_i;
      end
      if (req_addr_i == run_addr_lp) begin
        wakeup_addr_o <= req_data_i[wakeup_width_lp-1:0];
      end
    end
  end

  // reply kind, resolved one cycle later
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_v_r       <= 1'b0;
      send_dmem_r    <= 1'b0;
      send_invalid_r <= 1'b0;
    end else begin
      resp_v_r       <= accept;
      send_dmem_r    <= accept & ~req_we_i & is_dmem;
      send_invalid_r <= accept & ~req_we_i & ~is_dmem;
    end
  end

  assign resp_v_o    = resp_v_r;
  assign resp_data_o = send_dmem_r    ? dmem_rdata_i    :
                       send_invalid_r ? invalid_data_lp : '0;

  // RUN hands control to the sequencer, host is locked out next cycle
  run_locks_host_a: assert property (@(posedge clk_i) disable iff (reset_i)
    run_o |=> busy_i);

endmodule

//--- gs_dmem.sv
//////////////////////////////////////////////////
// local word memory with a host port and an
// engine port sharing one synchronous array;
// read data stays put until the next read
//////////////////////////////////////////////////

`timescale 1ns/1ps

module gs_dmem
  import gs_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          host_v_i,
  input  logic                          host_we_i,
  input  logic [dmem_addr_width_lp-1:0] host_addr_i,
  input  logic [data_width_lp-1:0]      host_wdata_i,
  input  logic                          eng_v_i,
  input  logic                          eng_we_i,
  input  logic [dmem_addr_width_lp-1:0] eng_addr_i,
  input  logic [data_width_lp-1:0]      eng_wdata_i,
  output logic [data_width_lp-1:0]      rdata_o
);

  logic [data_width_lp-1:0]      mem [dmem_els_lp];
  logic                          v;
  logic                          we;
  logic [dmem_addr_width_lp-1:0] addr;
  logic [data_width_lp-1:0]      wdata;

  // engine has priority on the shared port
  assign v     = eng_v_i | host_v_i;
  assign we    = eng_v_i ? eng_we_i    : host_we_i;
  assign addr  = eng_v_i ? eng_addr_i  : host_addr_i;
  assign wdata = eng_v_i ? eng_wdata_i : host_wdata_i;

  always_ff @(posedge clk_i) begin
    if (v) begin
      if (we) begin
        mem[addr] <= wdata;
      end else begin
        rdata_o <= mem[addr];
      end
    end
  end

  // host only gets in while the sequencer is idle
  port_exclusive_a: assert property (@(posedge clk_i) host_v_i |-> !eng_v_i);

endmodule

//--- gs_id_pool.sv
//////////////////////////////////////////////////
// scoreboard of outstanding gather loads: hands
// out the lowest free ID and remembers which DMEM
// word each ID's reply belongs to
//////////////////////////////////////////////////

`timescale 1ns/1ps

module gs_id_pool
  import gs_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          alloc_yumi_i,
  input  logic [dmem_addr_width_lp-1:0] alloc_index_i,
  input  logic                          ret_v_i,
  input  logic [id_width_lp-1:0]        ret_id_i,
  output logic                          alloc_v_o,
  output logic [id_width_lp-1:0]        alloc_id_o,
  output logic [dmem_addr_width_lp-1:0] dest_index_o,
  output logic                          all_free_o
);

  logic [id_els_lp-1:0]          free_r;
  logic [id_els_lp-1:0]          free_n;
  logic [dmem_addr_width_lp-1:0] dest_r [id_els_lp];

  assign alloc_v_o  = |free_r;
  assign all_free_o = &free_r;

  // priority pick, lowest index wins
  always_comb begin
    alloc_id_o = '0;
    for (int i = id_els_lp - 1; i >= 0; i--) begin
      if (free_r[i]) begin
        alloc_id_o = id_width_lp'(i);
      end
    end
  end

  // a return and an alloc never name the same ID
  always_comb begin
    free_n = free_r;
    if (ret_v_i) begin
      free_n[ret_id_i] = 1'b1;
    end
    if (alloc_yumi_i) begin
      free_n[alloc_id_o] = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      free_r <= '1;
    end else begin
      free_r <= free_n;
    end
  end

  // destination table
  always_ff @(posedge clk_i) begin
    if (alloc_yumi_i) begin
      dest_r[alloc_id_o] <= alloc_index_i;
    end
  end

  assign dest_index_o = dest_r[ret_id_i];

  // replies only for loads still in flight
  ret_in_use_a: assert property (@(posedge clk_i) disable iff (reset_i)
    ret_v_i |-> !free_r[ret_id_i]);

endmodule

//--- gs_sequencer.sv
//////////////////////////////////////////////////
// job FSM of the engine: walks base + i*stride,
// issues gather loads or scatter stores, lands
// gather replies in DMEM and ends each job with
// a single wakeup store of 1
//////////////////////////////////////////////////

`timescale 1ns/1ps

module gs_sequencer
  import gs_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          run_i,
  input  logic                          scatter_i,
  input  logic [len_width_lp-1:0]       len_i,
  input  logic [data_width_lp-1:0]      stride_i,
  input  logic [data_width_lp-1:0]      base_i,
  input  logic [wakeup_width_lp-1:0]    wakeup_addr_i,
  input  logic [data_width_lp-1:0]      dmem_rdata_i,
  input  logic                          alloc_v_i,
  input  logic [id_width_lp-1:0]        alloc_id_i,
  input  logic [dmem_addr_width_lp-1:0] dest_index_i,
  input  logic                          all_free_i,
  input  logic                          out_ready_i,
  input  logic                          ret_v_i,
  input  logic [data_width_lp-1:0]      ret_data_i,
  output logic                          busy_o,
  output logic                          eng_dmem_v_o,
  output logic                          eng_dmem_we_o,
  output logic [dmem_addr_width_lp-1:0] eng_dmem_addr_o,
  output logic [data_width_lp-1:0]      eng_dmem_wdata_o,
  output logic                          alloc_yumi_o,
  output logic [dmem_addr_width_lp-1:0] alloc_index_o,
  output logic                          out_v_o,
  output logic                          out_we_o,
  output logic [data_width_lp-1:0]      out_addr_o,
  output logic [data_width_lp-1:0]      out_data_o,
  output logic [id_width_lp-1:0]        out_id_o
);

  gs_state_e                  state_r;
  logic [len_width_lp-1:0]    cnt_r;
  logic [data_width_lp-1:0]   addr_r;
  logic [id_width_lp-1:0]     out_id_r;
  logic                       out_v_r;
  logic                       start;
  logic                       send;
  logic                       more;
  logic                       load;
  logic                       scatter_next;
  logic                       land_reply;

  // cnt_r counts elements already put on the out port
  assign start        = (state_r == e_idle) & run_i;
  assign send         = out_v_o & out_ready_i;
  assign more         = (cnt_r != len_i);
  assign load         = (state_r == e_gather) & more & alloc_v_i & (send | ~out_v_r);
  assign scatter_next = (state_r == e_scatter) & send & more;
  assign land_reply   = (state_r == e_gather) | (state_r == e_wakeup);

  assign busy_o = (state_r != e_idle);

  // first gather ID is taken in the RUN cycle, the pool is all free then
  assign alloc_yumi_o  = load | (start & ~scatter_i & (len_i != '0));
  assign alloc_index_o = cnt_r[dmem_addr_width_lp-1:0];

  // scatter reads word cnt_r, gather replies write their own slot
  assign eng_dmem_we_o    = land_reply;
  assign eng_dmem_v_o     = (land_reply & ret_v_i) | (start & scatter_i) | scatter_next;
  assign eng_dmem_addr_o  = land_reply ? dest_index_i : cnt_r[dmem_addr_width_lp-1:0];
  assign eng_dmem_wdata_o = ret_data_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_idle;
      cnt_r   <= '0;
      out_v_r <= 1'b0;
    end else begin
      case (state_r)
        e_idle: begin
          if (run_i) begin
            out_v_r <= (len_i != '0);
            if (len_i == '0) begin
              state_r <= e_wakeup;
            end else begin
              cnt_r   <= len_width_lp'(1);
              state_r <= scatter_i ? e_scatter : e_gather;
            end
          end
        end
        e_gather: begin
          if (load) begin
            cnt_r   <= cnt_r + 1'b1;
            out_v_r <= 1'b1;
          end else if (send) begin
            out_v_r <= 1'b0;
          end
          if (send & ~more) begin
            state_r <= e_wakeup;
          end
        end
        e_scatter: begin
          if (scatter_next) begin
            cnt_r <= cnt_r + 1'b1;
          end else if (send) begin
            out_v_r <= 1'b0;
            state_r <= e_wakeup;
          end
        end
        default: begin
          if (send) begin
            cnt_r   <= '0;
            state_r <= e_idle;
          end
        end
      endcase
    end
  end

  // running address, stepped by stride
  always_ff @(posedge clk_i) begin
    if (start) begin
      addr_r <= base_i;
    end else if (load | scatter_next) begin
      addr_r <= addr_r + stride_i;
    end
    if (alloc_yumi_o) begin
      out_id_r <= alloc_id_i;
    end
  end

  // wakeup waits for every gather ID to come home
  assign out_v_o    = (state_r == e_wakeup) ? all_free_i : out_v_r;
  assign out_we_o   = (state_r != e_gather);
  assign out_addr_o = (state_r == e_wakeup)
                    ? {{(data_width_lp-wakeup_width_lp){1'b0}}, wakeup_addr_i}
                    : addr_r;
  assign out_id_o   = out_id_r;

  always_comb begin
    case (state_r)
      e_scatter: out_data_o = dmem_rdata_i;
      e_wakeup:  out_data_o = data_width_lp'(1);
      default:   out_data_o = '0;
    endcase
  end

  out_stable_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (out_v_o && !out_ready_i) |=>
      $stable({out_v_o, out_we_o, out_addr_o, out_data_o, out_id_o}));

endmodule

//--- gather_scatter.sv
//////////////////////////////////////////////////
// gather-scatter engine top: host request port
// in, remote load/store port out, gather replies
// back in; only wires the four blocks together
//////////////////////////////////////////////////

`timescale 1ns/1ps

module gather_scatter
  import gs_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     req_v_i,
  input  logic                     req_we_i,
  input  logic [addr_width_lp-1:0] req_addr_i,
  input  logic [data_width_lp-1:0] req_data_i,
  output logic                     req_yumi_o,
  output logic                     resp_v_o,
  output logic [data_width_lp-1:0] resp_data_o,
  output logic                     out_v_o,
  output logic                     out_we_o,
  output logic [data_width_lp-1:0] out_addr_o,
  output logic [data_width_lp-1:0] out_data_o,
  output logic [id_width_lp-1:0]   out_id_o,
  input  logic                     out_ready_i,
  input  logic                     ret_v_i,
  input  logic [data_width_lp-1:0] ret_data_i,
  input  logic [id_width_lp-1:0]   ret_id_i
);

  // configuration and control
  logic                          run;
  logic                          scatter;
  logic                          busy;
  logic [len_width_lp-1:0]       len;
  logic [data_width_lp-1:0]      stride;
  logic [data_width_lp-1:0]      base;
  logic [wakeup_width_lp-1:0]    wakeup_addr;

  // DMEM ports
  logic                          host_dmem_v;
  logic                          host_dmem_we;
  logic [dmem_addr_width_lp-1:0] host_dmem_addr;
  logic [data_width_lp-1:0]      host_dmem_wdata;
  logic                          eng_dmem_v;
  logic                          eng_dmem_we;
  logic [dmem_addr_width_lp-1:0] eng_dmem_addr;
  logic [data_width_lp-1:0]      eng_dmem_wdata;
  logic [data_width_lp-1:0]      dmem_rdata;

  // ID pool
  logic                          alloc_v;
  logic                          alloc_yumi;
  logic [id_width_lp-1:0]        alloc_id;
  logic [dmem_addr_width_lp-1:0] alloc_index;
  logic [dmem_addr_width_lp-1:0] dest_index;
  logic                          all_free;

  gs_host_port host_port_i (
    .clk_i, .reset_i, .req_v_i, .req_we_i, .req_addr_i, .req_data_i,
    .busy_i(busy), .dmem_rdata_i(dmem_rdata),
    .req_yumi_o, .resp_v_o, .resp_data_o,
    .run_o(run), .scatter_o(scatter), .len_o(len), .stride_o(stride),
    .base_o(base), .wakeup_addr_o(wakeup_addr),
    .host_dmem_v_o(host_dmem_v), .host_dmem_we_o(host_dmem_we),
    .host_dmem_addr_o(host_dmem_addr), .host_dmem_wdata_o(host_dmem_wdata)
  );

  gs_sequencer sequencer_i (
    .clk_i, .reset_i,
    .run_i(run), .scatter_i(scatter), .len_i(len), .stride_i(stride),
    .base_i(base), .wakeup_addr_i(wakeup_addr), .dmem_rdata_i(dmem_rdata),
    .alloc_v_i(alloc_v), .alloc_id_i(alloc_id), .dest_index_i(dest_index),
    .all_free_i(all_free), .out_ready_i, .ret_v_i, .ret_data_i,
    .busy_o(busy),
    .eng_dmem_v_o(eng_dmem_v), .eng_dmem_we_o(eng_dmem_we),
    .eng_dmem_addr_o(eng_dmem_addr), .eng_dmem_wdata_o(eng_dmem_wdata),
    .alloc_yumi_o(alloc_yumi), .alloc_index_o(alloc_index),
    .out_v_o, .out_we_o, .out_addr_o, .out_data_o, .out_id_o
  );

  gs_dmem dmem_i (
    .clk_i,
    .host_v_i(host_dmem_v), .host_we_i(host_dmem_we),
    .host_addr_i(host_dmem_addr), .host_wdata_i(host_dmem_wdata),
    .eng_v_i(eng_dmem_v), .eng_we_i(eng_dmem_we),
    .eng_addr_i(eng_dmem_addr), .eng_wdata_i(eng_dmem_wdata),
    .rdata_o(dmem_rdata)
  );

  gs_id_pool id_pool_i (
    .clk_i, .reset_i,
    .alloc_yumi_i(alloc_yumi), .alloc_index_i(alloc_index),
    .ret_v_i, .ret_id_i,
    .alloc_v_o(alloc_v), .alloc_id_o(alloc_id),
    .dest_index_o(dest_index), .all_free_o(all_free)
  );

endmodule

//--- tb_remote_mem.sv
//////////////////////////////////////////////////
// remote memory model for the testbench: takes
// engine loads and stores, answers every load
// with address ^ key after a random delay and in
// random order, applies random back-pressure and
// keeps a count of stores
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_remote_mem
  import gs_pkg::*;
#(
  parameter logic [data_width_lp-1:0] key_p = 32'h5a3c_96e1
)
(
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     out_v_i,
  input  logic                     out_we_i,
  input  logic [data_width_lp-1:0] out_addr_i,
  input  logic [id_width_lp-1:0]   out_id_i,
  output logic                     out_ready_o,
  output logic                     ret_v_o,
  output logic [data_width_lp-1:0] ret_data_o,
  output logic [id_width_lp-1:0]   ret_id_o,
  output int                       pending_o,
  output int                       store_cnt_o
);

  logic [data_width_lp-1:0] pend_addr_q [$];
  logic [id_width_lp-1:0]   pend_id_q [$];

  initial begin
    out_ready_o = 1'b0;
    ret_v_o     = 1'b0;
    ret_data_o  = '0;
    ret_id_o    = '0;
    pending_o   = 0;
    store_cnt_o = 0;
  end

  always @(posedge clk_i) begin
    int k;
    if (reset_i) begin
      out_ready_o <= 1'b0;
      ret_v_o     <= 1'b0;
      pending_o   <= 0;
      store_cnt_o <= 0;
      pend_addr_q.delete();
      pend_id_q.delete();
    end else begin
      // stall about a quarter of the cycles
      out_ready_o <= ($urandom % 4) != 0;
      ret_v_o     <= 1'b0;
      // pick any outstanding load, so replies come back out of order
      if (pend_id_q.size() > 0 && ($urandom % 3) == 0) begin
        k = $urandom % pend_id_q.size();
        ret_v_o    <= 1'b1;
        ret_id_o   <= pend_id_q[k];
        ret_data_o <= pend_addr_q[k] ^ key_p;
        pend_addr_q.delete(k);
        pend_id_q.delete(k);
      end
      if (out_v_i && out_ready_o) begin
        if (out_we_i) begin
          store_cnt_o <= store_cnt_o + 1;
        end else begin
          pend_addr_q.push_back(out_addr_i);
          pend_id_q.push_back(out_id_i);
        end
      end
      pending_o <= pend_id_q.size();
    end
  end

endmodule

//--- tb_gather_scatter.sv
//////////////////////////////////////////////////
// testbench for the gather-scatter engine: runs
// host map tests, DMEM access and a list of
// gather and scatter jobs against a remote model;
// a scoreboard and assertions check every reply,
// every outgoing request and each wakeup store
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_gather_scatter
  import gs_pkg::*;
();

  localparam logic [31:0] seed_lp       = 32'h4d79_c27a;
  localparam logic [31:0] remote_key_lp = 32'h5a3c_96e1;
  localparam int          job_cnt_lp    = 5;

  // job list, the last one is an empty gather
  localparam bit          job_scatter_lp [job_cnt_lp] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
  localparam int          job_len_lp     [job_cnt_lp] = '{16, 12, 40, 40, 0};
  localparam logic [31:0] job_base_lp    [job_cnt_lp] =
    '{32'h0000_1000, 32'h2000_0000, 32'h0003_0000, 32'hffff_ff00, 32'h0000_0000};
  localparam logic [31:0] job_stride_lp  [job_cnt_lp] =
    '{32'h0000_0004, 32'hffff_fff0, 32'h0000_0003, 32'h0000_0101, 32'h0000_0000};

  logic                     clk;
  logic                     reset;
  logic                     req_v;
  logic                     req_we;
  logic [addr_width_lp-1:0] req_addr;
  logic [data_width_lp-1:0] req_data;
  logic                     req_yumi;
  logic                     resp_v;
  logic [data_width_lp-1:0] resp_data;
  logic                     out_v;
  logic                     out_we;
  logic [data_width_lp-1:0] out_addr;
  logic [data_width_lp-1:0] out_data;
  logic [id_width_lp-1:0]   out_id;
  logic                     out_ready;
  logic                     ret_v;
  logic [data_width_lp-1:0] ret_data;
  logic [id_width_lp-1:0]   ret_id;
  int                       pending;
  int                       store_cnt;

  // scoreboard state
  logic [data_width_lp-1:0]   shadow [dmem_els_lp];
  logic [data_width_lp-1:0]   exp_q [$];
  logic                       job_active;
  int                         jobs_done;
  logic                       cur_scatter;
  int                         cur_len;
  logic [data_width_lp-1:0]   cur_base;
  logic [data_width_lp-1:0]   cur_stride;
  logic [wakeup_width_lp-1:0] cur_wakeup;
  int                         load_k;
  int                         store_k;
  int                         checks = 0;
  int                         errors = 0;
  int                         cycles = 0;
  int                         timeout_limit;
  int                         stores_expected;

  gather_scatter gather_scatter_i (
    .clk_i(clk), .reset_i(reset),
    .req_v_i(req_v), .req_we_i(req_we), .req_addr_i(req_addr), .req_data_i(req_data),
    .req_yumi_o(req_yumi), .resp_v_o(resp_v), .resp_data_o(resp_data),
    .out_v_o(out_v), .out_we_o(out_we), .out_addr_o(out_addr), .out_data_o(out_data),
    .out_id_o(out_id), .out_ready_i(out_ready),
    .ret_v_i(ret_v), .ret_data_i(ret_data), .ret_id_i(ret_id)
  );

  tb_remote_mem #(.key_p(remote_key_lp)) remote_i (
    .clk_i(clk), .reset_i(reset),
    .out_v_i(out_v), .out_we_i(out_we), .out_addr_i(out_addr), .out_id_i(out_id),
    .out_ready_o(out_ready), .ret_v_o(ret_v), .ret_data_o(ret_data), .ret_id_o(ret_id),
    .pending_o(pending), .store_cnt_o(store_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // one host request, held until the engine takes it
  task automatic host_req(input logic we, input logic [addr_width_lp-1:0] addr,
                          input logic [data_width_lp-1:0] data);
    @(posedge clk);
    req_v    <= 1'b1;
    req_we   <= we;
    req_addr <= addr;
    req_data <= data;
    @(negedge clk);
    while (!req_yumi) @(negedge clk);
    @(posedge clk);
    req_v <= 1'b0;
  endtask

  task automatic fill_dmem(input int count);
    for (int i = 0; i < count; i++) begin
      host_req(1'b1, dmem_base_lp + 12'(i), $urandom);
    end
  endtask

  task automatic read_dmem(input int count);
    for (int i = 0; i < count; i++) begin
      host_req(1'b0, dmem_base_lp + 12'(i), '0);
    end
  endtask

  task automatic run_job(input int j);
    int                         done_before;
    logic [wakeup_width_lp-1:0] wakeup;
    done_before = jobs_done;
    wakeup      = 18'h2a000 + 18'(j);
    host_req(1'b1, len_addr_lp, 32'(job_len_lp[j]));
    host_req(1'b1, stride_addr_lp, job_stride_lp[j]);
    host_req(1'b1, base_addr_lp, job_base_lp[j]);
    host_req(1'b1, run_addr_lp, {job_scatter_lp[j], 13'($urandom), wakeup});
    // held across the job, taken only once the engine is idle again
    host_req(1'b1, 12'h010, $urandom);
    while (jobs_done == done_before) @(posedge clk);
  endtask

  // scoreboard for host replies and the outgoing port
  always @(posedge clk) begin
    if (reset) begin
      job_active <= 1'b0;
      jobs_done  <= 0;
      load_k     <= 0;
      store_k    <= 0;
      exp_q.delete();
    end else begin
      if (resp_v) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("host reply at %0t without a request to answer", $time);
        end else begin
          check_value(resp_data, exp_q.pop_front(), "host reply");
        end
      end
      if (req_v && req_yumi) begin
        if (req_we) begin
          exp_q.push_back('0);
          if (req_addr == len_addr_lp) cur_len <= int'(req_data[len_width_lp-1:0]);
          if (req_addr == stride_addr_lp) cur_stride <= req_data;
          if (req_addr == base_addr_lp) cur_base <= req_data;
          if (req_addr == run_addr_lp) begin
            job_active  <= 1'b1;
            cur_scatter <= req_data[31];
            cur_wakeup  <= req_data[wakeup_width_lp-1:0];
            load_k      <= 0;
            store_k     <= 0;
          end
          if (req_addr >= 12'h400 && req_addr < 12'h800) begin
            shadow[req_addr[dmem_addr_width_lp-1:0]] <= req_data;
          end
        end else if (req_addr >= 12'h400 && req_addr < 12'h800) begin
          exp_q.push_back(shadow[req_addr[dmem_addr_width_lp-1:0]]);
        end else begin
          exp_q.push_back(32'hdeadbeef);
        end
      end
      if (out_v && out_ready) begin
        if (!out_we) begin
          check_value(out_addr, cur_base + 32'(load_k) * cur_stride, "load address");
          load_k <= load_k + 1;
        end else if (cur_scatter && store_k < cur_len) begin
          check_value(out_addr, cur_base + 32'(store_k) * cur_stride, "store address");
          check_value(out_data, shadow[store_k], "store data");
          store_k <= store_k + 1;
        end else begin
          check_value(out_addr, 32'(cur_wakeup), "wakeup address");
          check_value(out_data, 32'd1, "wakeup data");
          if (!cur_scatter) begin
            check_value(32'(load_k), 32'(cur_len), "loads before wakeup");
            assert (pending == 0 && !ret_v) else begin
              errors++;
              $display("wakeup sent at %0t with gather loads still outstanding", $time);
            end
            // gathered words as the remote model answers them
            for (int i = 0; i < cur_len; i++) begin
              shadow[i] <= (cur_base + 32'(i) * cur_stride) ^ remote_key_lp;
            end
          end
          job_active <= 1'b0;
          jobs_done  <= jobs_done + 1;
        end
      end
    end
  end

  resp_reply_a: assert property (@(posedge clk) disable iff (reset)
    resp_v == $past(req_v && req_yumi))
    else begin
      errors++;
      $display("reply strobe at %0t is not one cycle after an accepted request", $time);
    end

  out_hold_a: assert property (@(posedge clk) disable iff (reset)
    (out_v && !out_ready) |=> (out_v && $stable({out_we, out_addr, out_data, out_id})))
    else begin
      errors++;
      $display("outgoing request changed under back-pressure at %0t", $time);
    end

  host_lock_a: assert property (@(posedge clk) disable iff (reset)
    job_active |-> !req_yumi)
    else begin
      errors++;
      $display("host request could be taken during a job at %0t", $time);
    end

  idle_quiet_a: assert property (@(posedge clk) disable iff (reset)
    !job_active |-> !out_v)
    else begin
      errors++;
      $display("outgoing request at %0t while no job is running", $time);
    end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_limit) begin
      $display("timeout: run did not finish within %0d cycles", timeout_limit);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin
    logic [addr_width_lp-1:0] dmem_addr;
    void'($urandom(seed_lp));
    reset    = 1'b1;
    req_v    = 1'b0;
    req_we   = 1'b0;
    req_addr = '0;
    req_data = '0;
    timeout_limit   = 2000;
    stores_expected = job_cnt_lp;
    for (int j = 0; j < job_cnt_lp; j++) begin
      timeout_limit += 20 * job_len_lp[j];
      if (job_scatter_lp[j]) stores_expected += job_len_lp[j];
    end
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    // loads outside DMEM, writes to unmapped space
    host_req(1'b0, run_addr_lp, '0);
    host_req(1'b0, len_addr_lp, '0);
    host_req(1'b0, stride_addr_lp, '0);
    host_req(1'b0, base_addr_lp, '0);
    host_req(1'b0, 12'h3ff, '0);
    host_req(1'b0, 12'h800, '0);
    host_req(1'b0, 12'hfff, '0);
    host_req(1'b1, 12'h0a5, $urandom);
    host_req(1'b1, 12'hc00, $urandom);

    for (int i = 0; i < 8; i++) begin
      dmem_addr = dmem_base_lp + 12'($urandom % dmem_els_lp);
      host_req(1'b1, dmem_addr, $urandom);
      host_req(1'b0, dmem_addr, '0);
    end

    // scatter jobs mix fresh host words with earlier gather results
    for (int j = 0; j < job_cnt_lp; j++) begin
      if (job_scatter_lp[j]) fill_dmem(job_len_lp[j] / 2);
      run_job(j);
      if (!job_scatter_lp[j]) read_dmem(job_len_lp[j]);
    end

    repeat (3) @(posedge clk);
    check_value(32'(exp_q.size()), 32'd0, "unanswered host requests");
    check_value(32'(store_cnt), 32'(stores_expected), "remote store count");
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- tb.f
gs_pkg.sv
gs_host_port.sv
gs_dmem.sv
gs_id_pool.sv
gs_sequencer.sv
gather_scatter.sv
tb_remote_mem.sv
tb_gather_scatter.sv
